//--- logic/game_pkg.sv
/*
 * game-side types shared by the trail recorder and its testbench
 * tile positions, headings, game states and the trail kinds to paint
 */
package game_pkg;

	// tile column or row inside the play area
	typedef logic [4:0] tile_coord_t;

	// row index inside one glyph
	typedef logic [3:0] glyph_row_t;

	// up and down count as vertical travel
	typedef enum logic [1:0]
	{
		UP    = 2'd0,
		DOWN  = 2'd1,
		LEFT  = 2'd2,
		RIGHT = 2'd3
	} heading_t;

	// play keeps the old encoding of 3'b010
	typedef enum logic [2:0]
	{
		TITLE = 3'b001,
		PLAY  = 3'b010,
		OVER  = 3'b100
	} game_state_t;

	// glyph selector, none means nothing to paint
	typedef enum logic [2:0]
	{
		NONE   = 3'd0,
		BLUE_H = 3'd1,
		BLUE_V = 3'd2,
		RED_H  = 3'd3,
		RED_V  = 3'd4,
		CORNER = 3'd5
	} trail_kind_t;

endpackage

//--- logic/fb_pkg.sv
/*
 * frame-buffer types for the write path toward the external memory
 * one word holds four 4-bit pixels, pixel 0 in the low nibble
 */
package fb_pkg;

	// word address into the frame buffer
	typedef logic [19:0] fb_addr_t;

	// four packed pixels
	typedef logic [15:0] fb_word_t;

	// palette index of one pixel
	typedef logic [3:0] pixel_t;

	// trail colors
	localparam pixel_t BLUE_PIX   = 4'd9;
	localparam pixel_t RED_PIX    = 4'd12;
	localparam pixel_t CORNER_PIX = 4'd15;

	// zero pixel leaves the background
	localparam pixel_t BLANK_PIX  = 4'd0;

endpackage

//--- logic/trail_glyph_rom.sv
/*
 * read-only glyph table for all trail kinds, filled from the glyph rule
 * registered read, data shows one cycle after kind and row
 */
`timescale 1ns/1ns

module trail_glyph_rom
	import game_pkg::*;
	import fb_pkg::*;
#(
	parameter int GLYPH_ROWS = 8
)
(
	input  logic        Clk,
	input  trail_kind_t kind,
	input  glyph_row_t  row,
	output fb_word_t    data
);

	// indexed by {kind, row}, rows past GLYPH_ROWS stay blank
	fb_word_t table_mem [0:127];

	function automatic fb_word_t glyph_word(input trail_kind_t k, input int r);
		pixel_t   color;
		logic     horiz;
		logic     vert;
		fb_word_t word;
		begin
			color = (k == BLUE_H || k == BLUE_V) ? BLUE_PIX :
				(k == RED_H || k == RED_V) ? RED_PIX : CORNER_PIX;
			horiz = (k == BLUE_H) || (k == RED_H) || (k == CORNER);
			vert  = (k == BLUE_V) || (k == RED_V) || (k == CORNER);
			word  = '0;
			if (r < GLYPH_ROWS)
			begin
				// middle two rows make the horizontal bar
				if (horiz && (r == GLYPH_ROWS / 2 - 1 || r == GLYPH_ROWS / 2))
					word = {color, color, color, color};
				// pixels 1 and 2 make the vertical bar
				if (vert)
					word = word | {BLANK_PIX, color, color, BLANK_PIX};
			end
			return word;
		end
	endfunction

	initial
	begin
		for (int i = 0; i < 128; i++)
			table_mem[i] = glyph_word(trail_kind_t'(i[6:4]), int'(i[3:0]));
	end

	always_ff @(posedge Clk)
	begin
		data <= table_mem[{kind, row}];
	end

endmodule

//--- logic/move_classifier.sv
/*
 * per-player move tracker, one instance per cycle color
 * pulses a move event for the tile just left and picks its trail kind
 */
`timescale 1ns/1ns

module move_classifier
	import game_pkg::*;
(
	input  logic        Clk,
	input  logic        rst,
	input  game_state_t game_state,
	input  logic        player_red,
	input  tile_coord_t x,
	input  tile_coord_t y,
	input  heading_t    heading,
	output logic        move_valid,
	output trail_kind_t move_kind,
	output tile_coord_t move_x,
	output tile_coord_t move_y
);

	tile_coord_t prev_x;
	tile_coord_t prev_y;
	heading_t    prev_heading;
	logic        playing;
	logic        moved;
	trail_kind_t kind;

	assign playing = (game_state == PLAY);
	assign moved   = (x != prev_x) || (y != prev_y);

	// heading held since entering the old tile decides corner or straight
	always_comb
	begin
		if (heading != prev_heading)
			kind = CORNER;
		else if (heading == UP || heading == DOWN)
			kind = player_red ? RED_V : BLUE_V;
		else
			kind = player_red ? RED_H : BLUE_H;
	end

	// follow the inputs outside play so a stale position never paints
	always_ff @(posedge Clk)
	begin
		if (rst || !playing || moved)
		begin
			prev_x       <= x;
			prev_y       <= y;
			prev_heading <= heading;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (rst)
			move_valid <= 1'b0;
		else
			move_valid <= playing && moved;
	end

	// event payload is the tile being left
	always_ff @(posedge Clk)
	begin
		if (playing && moved)
		begin
			move_kind <= kind;
			move_x    <= prev_x;
			move_y    <= prev_y;
		end
	end

endmodule

//--- logic/trail_painter.sv
/*
 * paints pending trail glyphs, blue before red, one glyph row per cycle
 * each row read reserves a credit, its write goes out one cycle later
 */
`timescale 1ns/1ns

module trail_painter
	import game_pkg::*;
	import fb_pkg::*;
#(
	parameter int GLYPH_ROWS  = 8,
	parameter int ROW_WORDS   = 160,
	parameter int PLAY_TOP    = 14,
	parameter int PLAY_LEFT   = 4,
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic        Clk,
	input  logic        rst,
	input  game_state_t game_state,
	input  logic        blue_valid,
	input  trail_kind_t blue_kind,
	input  tile_coord_t blue_x,
	input  tile_coord_t blue_y,
	input  logic        red_valid,
	input  trail_kind_t red_kind,
	input  tile_coord_t red_x,
	input  tile_coord_t red_y,
	input  logic        credit_return,
	output logic        wr_valid,
	output fb_addr_t    wr_addr,
	output fb_word_t    wr_data,
	output logic        idle
);

	localparam int         CREDIT_W  = $clog2(QUEUE_DEPTH + 1);
	localparam glyph_row_t LAST_ROW  = glyph_row_t'(GLYPH_ROWS - 1);
	localparam fb_addr_t   LINE_STEP = fb_addr_t'(ROW_WORDS);

	typedef enum logic [1:0] {IDLE, LOAD, PAINT, FLUSH} paint_state_t;

	paint_state_t        state;
	logic                playing;
	logic                blue_pend;
	logic                red_pend;
	trail_kind_t         blue_pkind;
	trail_kind_t         red_pkind;
	tile_coord_t         blue_px;
	tile_coord_t         blue_py;
	tile_coord_t         red_px;
	tile_coord_t         red_py;
	logic                take_blue;
	logic                take_red;
	trail_kind_t         job_kind;
	tile_coord_t         job_x;
	tile_coord_t         job_y;
	fb_addr_t            base_addr;
	glyph_row_t          rd_row;
	fb_addr_t            rd_addr;
	logic                issue;
	logic [CREDIT_W-1:0] credits;
	logic                stage_valid;
	fb_addr_t            stage_addr;

	assign playing   = (game_state == PLAY);
	assign take_blue = (state == IDLE) && playing && blue_pend;
	assign take_red  = (state == IDLE) && playing && !blue_pend && red_pend;
	assign issue     = (state == PAINT) && playing && (credits != '0);

	// one slot per player, a newer event overwrites an unstarted job
	always_ff @(posedge Clk)
	begin
		if (rst || !playing)
		begin
			blue_pend <= 1'b0;
			red_pend  <= 1'b0;
		end
		else
		begin
			if (blue_valid)
				blue_pend <= 1'b1;
			else if (take_blue)
				blue_pend <= 1'b0;
			if (red_valid)
				red_pend <= 1'b1;
			else if (take_red)
				red_pend <= 1'b0;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (blue_valid)
		begin
			blue_pkind <= blue_kind;
			blue_px    <= blue_x;
			blue_py    <= blue_y;
		end
		if (red_valid)
		begin
			red_pkind <= red_kind;
			red_px    <= red_x;
			red_py    <= red_y;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (take_blue)
		begin
			job_kind <= blue_pkind;
			job_x    <= blue_px;
			job_y    <= blue_py;
		end
		else if (take_red)
		begin
			job_kind <= red_pkind;
			job_x    <= red_px;
			job_y    <= red_py;
		end
	end

	// top-left word of the glyph, used in LOAD
	assign base_addr = fb_addr_t'((PLAY_TOP + job_y * GLYPH_ROWS) * ROW_WORDS
		+ PLAY_LEFT + job_x);

	always_ff @(posedge Clk)
	begin
		if (rst)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE:
					if (take_blue || take_red)
						state <= LOAD;
				LOAD:
					state <= playing ? PAINT : IDLE;
				PAINT:
					// leaving play aborts, the last read still gets written
					if (!playing || (issue && rd_row == LAST_ROW))
						state <= FLUSH;
				FLUSH:
					state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// one screen line per glyph row
	always_ff @(posedge Clk)
	begin
		if (state == LOAD)
		begin
			rd_row  <= '0;
			rd_addr <= base_addr;
		end
		else if (issue)
		begin
			rd_row  <= rd_row + 1'b1;
			rd_addr <= rd_addr + LINE_STEP;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (rst)
			credits <= CREDIT_W'(QUEUE_DEPTH);
		else if (issue && !credit_return)
			credits <= credits - 1'b1;
		else if (!issue && credit_return)
			credits <= credits + 1'b1;
	end

	// write stage lines up with the rom output
	always_ff @(posedge Clk)
	begin
		if (rst)
			stage_valid <= 1'b0;
		else
			stage_valid <= issue;
	end

	always_ff @(posedge Clk)
	begin
		if (issue)
			stage_addr <= rd_addr;
	end

	trail_glyph_rom #(
		.GLYPH_ROWS(GLYPH_ROWS)
	) i_trail_glyph_rom (
		.Clk (Clk),
		.kind(job_kind),
		.row (rd_row),
		.data(wr_data)
	);

	assign wr_valid = stage_valid;
	assign wr_addr  = stage_addr;
	assign idle     = (state == IDLE) && !blue_pend && !red_pend && !blue_valid && !red_valid;

endmodule

//--- logic/fb_write_queue.sv
/*
 * write FIFO in front of the frame buffer, head shown while non-empty
 * every accepted word returns one credit to the painter
 */
`timescale 1ns/1ns

module fb_write_queue
	import fb_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic     Clk,
	input  logic     rst,
	input  logic     wr_valid,
	input  fb_addr_t wr_addr,
	input  fb_word_t wr_data,
	input  logic     fb_ready,
	output logic     credit_return,
	output logic     fb_we,
	output fb_addr_t fb_addr,
	output fb_word_t fb_data,
	output logic     empty
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(QUEUE_DEPTH - 1);

	fb_addr_t         addr_mem [0:QUEUE_DEPTH-1];
	fb_word_t         data_mem [0:QUEUE_DEPTH-1];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             pop;

	// credits keep the writer from ever overfilling
	assign empty         = (count == '0);
	assign fb_we         = !empty;
	assign fb_addr       = addr_mem[rd_ptr];
	assign fb_data       = data_mem[rd_ptr];
	assign pop           = fb_we && fb_ready;
	assign credit_return = pop;

	always_ff @(posedge Clk)
	begin
		if (wr_valid)
		begin
			addr_mem[wr_ptr] <= wr_addr;
			data_mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_valid)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			if (wr_valid && !pop)
				count <= count + 1'b1;
			else if (!wr_valid && pop)
				count <= count - 1'b1;
		end
	end

endmodule

//--- logic/light_trail_top.sv
/*
 * light-cycle trail recorder, paints trail glyphs behind both cycles
 * takes positions per frame, drives frame-buffer writes with a ready handshake
 */
`timescale 1ns/1ns

module light_trail_top
	import game_pkg::*;
	import fb_pkg::*;
#(
	parameter int GLYPH_ROWS  = 8,
	parameter int ROW_WORDS   = 160,
	parameter int PLAY_TOP    = 14,
	parameter int PLAY_LEFT   = 4,
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic        Clk,
	input  logic        rst,
	input  game_state_t game_state,
	input  tile_coord_t blue_x,
	input  tile_coord_t blue_y,
	input  heading_t    blue_heading,
	input  tile_coord_t red_x,
	input  tile_coord_t red_y,
	input  heading_t    red_heading,
	input  logic        fb_ready,
	output logic        busy,
	output logic        fb_we,
	output fb_addr_t    fb_addr,
	output fb_word_t    fb_data
);

	logic        blue_valid;
	trail_kind_t blue_kind;
	tile_coord_t blue_mx;
	tile_coord_t blue_my;
	logic        red_valid;
	trail_kind_t red_kind;
	tile_coord_t red_mx;
	tile_coord_t red_my;
	logic        wr_valid;
	fb_addr_t    wr_addr;
	fb_word_t    wr_data;
	logic        credit_return;
	logic        painter_idle;
	logic        queue_empty;

	move_classifier i_blue_classifier (
		.Clk       (Clk),
		.rst       (rst),
		.game_state(game_state),
		.player_red(1'b0),
		.x         (blue_x),
		.y         (blue_y),
		.heading   (blue_heading),
		.move_valid(blue_valid),
		.move_kind (blue_kind),
		.move_x    (blue_mx),
		.move_y    (blue_my)
	);

	move_classifier i_red_classifier (
		.Clk       (Clk),
		.rst       (rst),
		.game_state(game_state),
		.player_red(1'b1),
		.x         (red_x),
		.y         (red_y),
		.heading   (red_heading),
		.move_valid(red_valid),
		.move_kind (red_kind),
		.move_x    (red_mx),
		.move_y    (red_my)
	);

	trail_painter #(
		.GLYPH_ROWS (GLYPH_ROWS),
		.ROW_WORDS  (ROW_WORDS),
		.PLAY_TOP   (PLAY_TOP),
		.PLAY_LEFT  (PLAY_LEFT),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_trail_painter (
		.Clk          (Clk),
		.rst          (rst),
		.game_state   (game_state),
		.blue_valid   (blue_valid),
		.blue_kind    (blue_kind),
		.blue_x       (blue_mx),
		.blue_y       (blue_my),
		.red_valid    (red_valid),
		.red_kind     (red_kind),
		.red_x        (red_mx),
		.red_y        (red_my),
		.credit_return(credit_return),
		.wr_valid     (wr_valid),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.idle         (painter_idle)
	);

	fb_write_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_fb_write_queue (
		.Clk          (Clk),
		.rst          (rst),
		.wr_valid     (wr_valid),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.fb_ready     (fb_ready),
		.credit_return(credit_return),
		.fb_we        (fb_we),
		.fb_addr      (fb_addr),
		.fb_data      (fb_data),
		.empty        (queue_empty)
	);

	// busy until nothing pending, nothing painting and the queue drained
	assign busy = !(painter_idle && queue_empty);

endmodule

//--- sim/trail_model.svh
/*
 * reference model for the trail recorder testbench, included inside the testbench module
 * turns every driven position into the frame-buffer words it should produce
 */
`ifndef TRAIL_MODEL_SVH
`define TRAIL_MODEL_SVH

// last tile and heading per player, 0 is blue and 1 is red
tile_coord_t last_x [2];
tile_coord_t last_y [2];
heading_t    last_h [2];

// one glyph row built pixel by pixel
function automatic fb_word_t expected_row(input trail_kind_t kind, input int r);
	pixel_t   color;
	fb_word_t word;
	bit       bar_h;
	bit       bar_v;
	int       p;
	begin
		if (kind == CORNER)
			color = CORNER_PIX;
		else if (kind == RED_H || kind == RED_V)
			color = RED_PIX;
		else
			color = BLUE_PIX;
		bar_h = (kind != BLUE_V) && (kind != RED_V) && (r == GLYPH_ROWS / 2 - 1 || r == GLYPH_ROWS / 2);
		bar_v = (kind != BLUE_H) && (kind != RED_H);
		word  = '0;
		for (p = 0; p < 4; p++)
			if (bar_h || (bar_v && (p == 1 || p == 2)))
				word[p*4 +: 4] = color;
		return word;
	end
endfunction

function automatic fb_addr_t expected_addr(input tile_coord_t x, input tile_coord_t y, input int r);
	int a;
	begin
		a = (PLAY_TOP + int'(y) * GLYPH_ROWS + r) * ROW_WORDS + PLAY_LEFT + int'(x);
		return fb_addr_t'(a);
	end
endfunction

// a tile change in play paints the tile left, corner if the heading changed
task automatic model_move(input int p, input game_state_t st, input tile_coord_t x,
	input tile_coord_t y, input heading_t h);
	trail_kind_t kind;
	bit          moved;
	int          r;
	begin
		moved = (x != last_x[p]) || (y != last_y[p]);
		if (st == PLAY && moved)
		begin
			if (h != last_h[p])
				kind = CORNER;
			else if (h == UP || h == DOWN)
				kind = (p == 1) ? RED_V : BLUE_V;
			else
				kind = (p == 1) ? RED_H : BLUE_H;
			for (r = 0; r < GLYPH_ROWS; r++)
			begin
				exp_addr.push_back(expected_addr(last_x[p], last_y[p], r));
				exp_data.push_back(expected_row(kind, r));
			end
		end
		if (st != PLAY || moved)
		begin
			last_x[p] = x;
			last_y[p] = y;
			last_h[p] = h;
		end
	end
endtask

`endif

//--- sim/light_trail_tb.sv
/*
 * testbench for the light-cycle trail recorder
 * random moves per step, every accepted frame-buffer word checked against the model
 */
`timescale 1ns/1ns

module light_trail_tb
	import game_pkg::*;
	import fb_pkg::*;
();

	localparam int GLYPH_ROWS      = 8;
	localparam int ROW_WORDS       = 160;
	localparam int PLAY_TOP        = 14;
	localparam int PLAY_LEFT       = 4;
	localparam int QUEUE_DEPTH     = 4;
	localparam int STEPS           = 64;
	localparam int PLAY_STEPS      = STEPS - 8;
	localparam int WATCHDOG_CYCLES = STEPS * 2 * GLYPH_ROWS * 6 + 200;

	logic        Clk;
	logic        rst;
	game_state_t game_state;
	tile_coord_t blue_x;
	tile_coord_t blue_y;
	heading_t    blue_heading;
	tile_coord_t red_x;
	tile_coord_t red_y;
	heading_t    red_heading;
	logic        fb_ready;
	logic        busy;
	logic        fb_we;
	fb_addr_t    fb_addr;
	fb_word_t    fb_data;

	fb_addr_t    exp_addr [$];
	fb_word_t    exp_data [$];
	int          checks     = 0;
	int          mismatches = 0;
	int          failures   = 0;
	int          accepted   = 0;
	int          ready_pct  = 60;
	bit          stall_mode = 1'b0;
	int          stall_cnt  = 0;
	bit          held       = 1'b0;
	int unsigned seed;
	int          i;
	int          base;

	`include "trail_model.svh"

	light_trail_top #(
		.GLYPH_ROWS (GLYPH_ROWS),
		.ROW_WORDS  (ROW_WORDS),
		.PLAY_TOP   (PLAY_TOP),
		.PLAY_LEFT  (PLAY_LEFT),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_light_trail_top (
		.Clk         (Clk),
		.rst         (rst),
		.game_state  (game_state),
		.blue_x      (blue_x),
		.blue_y      (blue_y),
		.blue_heading(blue_heading),
		.red_x       (red_x),
		.red_y       (red_y),
		.red_heading (red_heading),
		.fb_ready    (fb_ready),
		.busy        (busy),
		.fb_we       (fb_we),
		.fb_addr     (fb_addr),
		.fb_data     (fb_data)
	);

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		begin
			checks++;
			if (got !== exp)
			begin
				mismatches++;
				$display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			end
		end
	endtask

	// move the selected players one tile, who below zero picks them at random
	task automatic drive_step(input game_state_t st, input int who);
		tile_coord_t nx [2];
		tile_coord_t ny [2];
		heading_t    nh [2];
		logic [1:0]  sel;
		logic [1:0]  rnd;
		int          p;
		begin
			@(posedge Clk);
			sel   = (who < 0) ? 2'($urandom_range(3, 1)) : 2'(who);
			nx[0] = blue_x;
			ny[0] = blue_y;
			nh[0] = blue_heading;
			nx[1] = red_x;
			ny[1] = red_y;
			nh[1] = red_heading;
			for (p = 0; p < 2; p++)
			begin
				if (sel[p])
				begin
					rnd = 2'($urandom);
					case (rnd)
						2'd0: ny[p] = ny[p] - 5'd1;
						2'd1: ny[p] = ny[p] + 5'd1;
						2'd2: nx[p] = nx[p] - 5'd1;
						default: nx[p] = nx[p] + 5'd1;
					endcase
					// keep the heading half the time so straight glyphs show up
					rnd = 2'($urandom);
					if ($urandom % 2)
						nh[p] = heading_t'(rnd);
				end
			end
			@(negedge Clk);
			game_state   = st;
			blue_x       = nx[0];
			blue_y       = ny[0];
			blue_heading = nh[0];
			red_x        = nx[1];
			red_y        = ny[1];
			red_heading  = nh[1];
			model_move(0, st, nx[0], ny[0], nh[0]);
			model_move(1, st, nx[1], ny[1], nh[1]);
		end
	endtask

	task automatic wait_until_idle();
		begin
			repeat (2) @(negedge Clk);
			while (busy)
				@(negedge Clk);
		end
	endtask

	task automatic expect_queue_drained();
		begin
			if (exp_addr.size() != 0)
			begin
				failures++;
				$display("%0d expected frame-buffer writes never arrived by %0t ns",
					exp_addr.size(), $time);
				exp_addr.delete();
				exp_data.delete();
			end
		end
	endtask

	initial
	begin
		Clk = 1'b0;
		forever
			#2 Clk = ~Clk;
	end

	// long low stretches in stall mode, otherwise random
	initial
	begin
		fb_ready = 1'b0;
		forever
		begin
			@(negedge Clk);
			if (stall_mode)
			begin
				fb_ready  = (stall_cnt == 0);
				stall_cnt = (stall_cnt == 10) ? 0 : stall_cnt + 1;
			end
			else
				fb_ready = ($urandom % 100) < ready_pct;
		end
	end

	// frame-buffer side, handshake completes on fb_we with fb_ready
	always @(posedge Clk)
	begin
		if (rst)
			held = 1'b0;
		else
		begin
			// a stalled head must stay the next expected word
			if (held)
			begin
				check_value("fb_we while stalled", fb_we, 1);
				if (exp_addr.size() != 0)
				begin
					check_value("fb_addr while stalled", fb_addr, exp_addr[0]);
					check_value("fb_data while stalled", fb_data, exp_data[0]);
				end
			end
			held = fb_we && !fb_ready;
			if (fb_we && fb_ready)
			begin
				accepted++;
				if (exp_addr.size() == 0)
				begin
					failures++;
					$display("unexpected frame-buffer write to %0h at %0t ns", fb_addr, $time);
				end
				else
				begin
					check_value("fb_addr", fb_addr, exp_addr.pop_front());
					check_value("fb_data", fb_data, exp_data.pop_front());
				end
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge Clk);
		$display("watchdog expired after %0d cycles, the DUT never finished", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		seed         = $urandom(9);
		rst          = 1'b1;
		game_state   = TITLE;
		blue_x       = 5'd2;
		blue_y       = 5'd2;
		blue_heading = RIGHT;
		red_x        = 5'd20;
		red_y        = 5'd20;
		red_heading  = LEFT;
		model_move(0, TITLE, blue_x, blue_y, blue_heading);
		model_move(1, TITLE, red_x, red_y, red_heading);
		repeat (8) @(posedge Clk);
		@(negedge Clk);
		rst = 1'b0;
		check_value("fb_we after reset", fb_we, 0);
		check_value("busy after reset", busy, 0);

		// wander outside play, then enter play in place
		repeat (4)
		begin
			drive_step(TITLE, 3);
			wait_until_idle();
		end
		drive_step(PLAY, 0);
		wait_until_idle();
		expect_queue_drained();

		for (i = 0; i < PLAY_STEPS; i++)
		begin
			stall_mode = (i % 8 == 7);
			drive_step(PLAY, -1);
			wait_until_idle();
			expect_queue_drained();
		end
		stall_mode = 1'b0;

		// leave play with the queue full, blue stalls and red never starts
		ready_pct = 0;
		base      = accepted;
		drive_step(PLAY, 3);
		repeat (12) @(negedge Clk);
		game_state = OVER;
		ready_pct  = 60;
		wait_until_idle();
		check_value("words drained after abort", accepted - base, QUEUE_DEPTH);
		exp_addr.delete();
		exp_data.delete();

		drive_step(PLAY, 0);
		wait_until_idle();
		expect_queue_drained();
		drive_step(PLAY, 3);
		wait_until_idle();
		expect_queue_drained();

		$display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- light_trail.f
logic/game_pkg.sv
logic/fb_pkg.sv
logic/trail_glyph_rom.sv
logic/move_classifier.sv
logic/trail_painter.sv
logic/fb_write_queue.sv
logic/light_trail_top.sv
+incdir+sim
sim/light_trail_tb.sv
